// File: hdl/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

`define CTRL_OP_W     6
`define CTRL_FUNCT_W  6
`define ALUCLS_W      3
`define ALU_OP_W      3
`define FPU_OP_W      4
`define FPU_CNT_W     3

// opcodes
`define OP_RTYPE  6'b000000
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_ADDI   6'b001000
`define OP_SLTI   6'b001010
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_LUI    6'b001111
`define OP_FADD   6'b010000
`define OP_FSUB   6'b010001
`define OP_FMUL   6'b010010
`define OP_FDIV   6'b010011
`define OP_FNEG   6'b010100
`define OP_FABS   6'b010101
`define OP_FSQRT  6'b010110
`define OP_FSLT   6'b010111
`define OP_LW     6'b100011
`define OP_SW     6'b101011
`define OP_FLW    6'b110011
`define OP_FSW    6'b110110

// R-type funct codes
`define FN_SLL    6'b000000
`define FN_SRL    6'b000010
`define FN_JR     6'b001000
`define FN_JALR   6'b001001
`define FN_ADD    6'b100000
`define FN_SUB    6'b100010
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_SLT    6'b101010

// class handed from sequencer to ALU decoder
`define ALUCLS_ADD    3'b000
`define ALUCLS_SUB    3'b001
`define ALUCLS_AND    3'b010
`define ALUCLS_OR     3'b011
`define ALUCLS_SLT    3'b100
`define ALUCLS_RTYPE  3'b111

`define ALU_ADD  3'b010
`define ALU_SUB  3'b110
`define ALU_AND  3'b000
`define ALU_OR   3'b001
`define ALU_SLT  3'b111

`define FPU_ADD   4'b0000
`define FPU_SUB   4'b0001
`define FPU_MUL   4'b0010
`define FPU_DIV   4'b0011
`define FPU_NEG   4'b0100
`define FPU_ABS   4'b0101
`define FPU_SQRT  4'b0110
`define FPU_SLT   4'b0111

// wait states spent in stFpuWait
`define FPU_LAT_ADD    3'd3
`define FPU_LAT_MUL    3'd2
`define FPU_LAT_DIV    3'd5
`define FPU_LAT_UNARY  3'd1

`endif

// File: hdl/ctrlPkg.sv
`default_nettype none

`include "ctrl_params.svh"

package ctrlPkg;

    typedef enum logic [4:0] {
        stFetch,
        stFetchWait,
        stDecode,
        stMemAdr,
        stMemRead,
        stMemReadWait,
        stMemWriteback,
        stMemWrite,
        stExecute,
        stAluWriteback,
        stJumpAndLinkReg,
        stLoadUi,
        stLuiWriteback,
        stImmExecute,
        stImmWriteback,
        stBranch,        // beq and bne
        stJump,          // j and jal
        stFpuExecute,
        stFpuWait,
        stFpuWriteback,
        stFsltExecute,
        stFsltWriteback,
        stIllegalOp
    } seqState_t;

    // registered outputs of the main sequencer
    typedef struct packed {
        logic                     iOrD;
        logic                     memWrite;
        logic                     irWrite;
        logic                     pcWriteReq;  // before the jr/jalr override
        logic                     branch;
        logic                     toggleEqual; // bne inverts the zero flag
        logic [1:0]               pcSrcReq;
        logic [`FPU_OP_W-1:0]     fpuControl;
        logic                     aluOrFpu;
        logic [1:0]               aluSrcB;
        logic                     aluSrcA;
        logic                     andiOri;
        logic                     regWrite;
        logic [1:0]               regDst;
        logic [1:0]               memToReg;
        logic                     bOrL;
        logic [`ALUCLS_W-1:0]     aluClass;
    } seqCtrl_t;

    typedef struct packed {
        logic [`ALU_OP_W-1:0] aluControl;
        logic                 shift;
        logic                 shiftRight;
    } aluCtrl_t;

    // regConcat is {rs, rt, rd}, a set bit selects the float bank
    typedef struct packed {
        logic       pcWrite;
        logic [1:0] pcSrc;
        logic [2:0] regConcat;
    } pcCtrl_t;

endpackage

`default_nettype wire

// File: hdl/mainSequencer.sv
`default_nettype none

`include "ctrl_params.svh"

module mainSequencer
    import ctrlPkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`CTRL_OP_W-1:0]    op,
    input  logic [`CTRL_FUNCT_W-1:0] funct,
    output seqCtrl_t                 ctrl,
    output seqState_t                state
);

    logic [`FPU_CNT_W-1:0] waitCnt;
    logic                  opKnown;

    // common values when heading back to fetch
    function automatic seqCtrl_t toFetch(seqCtrl_t c);
        seqCtrl_t n;
        n = c;
        n.iOrD        = 1'b0;
        n.memWrite    = 1'b0;
        n.regWrite    = 1'b0;
        n.branch      = 1'b0;
        n.toggleEqual = 1'b0;
        n.aluOrFpu    = 1'b0;
        n.aluSrcA     = 1'b0;
        n.aluSrcB     = 2'b01;       // pc + 4
        n.aluClass    = `ALUCLS_ADD;
        n.pcSrcReq    = 2'b00;
        n.pcWriteReq  = 1'b1;
        return n;
    endfunction

    function automatic logic [`ALUCLS_W-1:0] immClass(logic [`CTRL_OP_W-1:0] o);
        case (o)
            `OP_ANDI: return `ALUCLS_AND;
            `OP_ORI:  return `ALUCLS_OR;
            `OP_SLTI: return `ALUCLS_SLT;
            default:  return `ALUCLS_ADD;
        endcase
    endfunction

    function automatic logic [`FPU_OP_W-1:0] fpuCode(logic [`CTRL_OP_W-1:0] o);
        case (o)
            `OP_FSUB:  return `FPU_SUB;
            `OP_FMUL:  return `FPU_MUL;
            `OP_FDIV:  return `FPU_DIV;
            `OP_FNEG:  return `FPU_NEG;
            `OP_FABS:  return `FPU_ABS;
            `OP_FSQRT: return `FPU_SQRT;
            `OP_FSLT:  return `FPU_SLT;
            default:   return `FPU_ADD;
        endcase
    endfunction

    function automatic logic [`FPU_CNT_W-1:0] fpuLatency(logic [`CTRL_OP_W-1:0] o);
        case (o)
            `OP_FADD, `OP_FSUB:  return `FPU_LAT_ADD;
            `OP_FMUL, `OP_FSQRT: return `FPU_LAT_MUL;
            `OP_FDIV:            return `FPU_LAT_DIV;
            default:             return `FPU_LAT_UNARY;
        endcase
    endfunction

    always_comb begin
        case (op)
            `OP_LW, `OP_FLW, `OP_SW, `OP_FSW, `OP_RTYPE, `OP_LUI,
            `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_SLTI,
            `OP_BEQ, `OP_BNE, `OP_J, `OP_JAL,
            `OP_FADD, `OP_FSUB, `OP_FMUL, `OP_FDIV,
            `OP_FSQRT, `OP_FNEG, `OP_FABS, `OP_FSLT: opKnown = 1'b1;
            default: opKnown = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state           <= stFetch;
            ctrl            <= '0;
            ctrl.pcWriteReq <= 1'b1;
            ctrl.aluSrcB    <= 2'b01;
            waitCnt         <= '0;
        end else begin
            case (state)
                stFetch: begin
                    state           <= stFetchWait;
                    ctrl.pcWriteReq <= 1'b0;
                    ctrl.irWrite    <= 1'b1; // instruction register loads in FetchWait
                end
                stFetchWait: begin
                    state         <= stDecode;
                    ctrl.irWrite  <= 1'b0;
                    ctrl.aluSrcA  <= 1'b0;
                    ctrl.aluSrcB  <= 2'b11; // branch target precompute
                    ctrl.aluClass <= `ALUCLS_ADD;
                end
                stDecode: begin
                    case (op)
                        `OP_LW, `OP_FLW, `OP_SW, `OP_FSW: begin
                            state         <= stMemAdr;
                            ctrl.aluSrcA  <= 1'b1;
                            ctrl.aluSrcB  <= 2'b10;
                            ctrl.aluClass <= `ALUCLS_ADD;
                        end
                        `OP_LUI: begin
                            state         <= stLoadUi;
                            ctrl.aluSrcA  <= 1'b1;
                            ctrl.aluSrcB  <= 2'b11;
                            ctrl.bOrL     <= 1'b1;
                            ctrl.aluClass <= `ALUCLS_ADD;
                        end
                        `OP_RTYPE: begin
                            ctrl.aluSrcA  <= 1'b1;
                            ctrl.aluSrcB  <= 2'b00;
                            ctrl.aluClass <= `ALUCLS_RTYPE;
                            if (funct == `FN_JALR) begin
                                state         <= stJumpAndLinkReg;
                                ctrl.regDst   <= 2'b10; // link register
                                ctrl.memToReg <= 2'b10;
                                ctrl.regWrite <= 1'b1;
                            end else begin
                                state <= stExecute;
                            end
                        end
                        `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_SLTI: begin
                            state         <= stImmExecute;
                            ctrl.aluSrcA  <= 1'b1;
                            ctrl.aluSrcB  <= 2'b10;
                            ctrl.andiOri  <= (op == `OP_ANDI) || (op == `OP_ORI);
                            ctrl.aluClass <= immClass(op);
                        end
                        `OP_BEQ, `OP_BNE: begin
                            state            <= stBranch;
                            ctrl.aluSrcA     <= 1'b1;
                            ctrl.aluSrcB     <= 2'b00;
                            ctrl.aluClass    <= `ALUCLS_SUB;
                            ctrl.pcSrcReq    <= 2'b01;
                            ctrl.branch      <= 1'b1;
                            ctrl.toggleEqual <= (op == `OP_BNE);
                        end
                        `OP_J, `OP_JAL: begin
                            state           <= stJump;
                            ctrl.pcSrcReq   <= 2'b10;
                            ctrl.pcWriteReq <= 1'b1;
                            if (op == `OP_JAL) begin
                                ctrl.regDst   <= 2'b10;
                                ctrl.memToReg <= 2'b10;
                                ctrl.regWrite <= 1'b1;
                            end
                        end
                        `OP_FADD, `OP_FSUB, `OP_FMUL, `OP_FDIV,
                        `OP_FSQRT, `OP_FNEG, `OP_FABS, `OP_FSLT: begin
                            ctrl.aluSrcA    <= 1'b1;
                            ctrl.aluSrcB    <= 2'b00;
                            ctrl.aluOrFpu   <= 1'b1;
                            ctrl.fpuControl <= fpuCode(op);
                            waitCnt         <= fpuLatency(op);
                            if (op == `OP_FSLT)
                                state <= stFsltExecute;
                            else if (op == `OP_FNEG || op == `OP_FABS)
                                state <= stFpuWait; // no execute cycle for unary ops
                            else
                                state <= stFpuExecute;
                        end
                        default: state <= stIllegalOp;
                    endcase
                end
                stMemAdr: begin
                    ctrl.iOrD <= 1'b1;
                    if (op == `OP_LW || op == `OP_FLW) begin
                        state <= stMemRead;
                    end else begin
                        state         <= stMemWrite;
                        ctrl.memWrite <= 1'b1;
                    end
                end
                stMemRead:     state <= stMemReadWait;
                stMemReadWait: begin
                    state         <= stMemWriteback;
                    ctrl.regDst   <= 2'b00;
                    ctrl.memToReg <= 2'b01; // memory data
                    ctrl.regWrite <= 1'b1;
                end
                stExecute, stJumpAndLinkReg: begin
                    state           <= stAluWriteback;
                    ctrl.regDst     <= 2'b01;
                    ctrl.memToReg   <= 2'b00;
                    ctrl.bOrL       <= 1'b0;
                    ctrl.regWrite   <= 1'b1;
                    ctrl.pcWriteReq <= 1'b0;
                end
                stLoadUi: begin
                    state         <= stLuiWriteback;
                    ctrl.regDst   <= 2'b00;
                    ctrl.memToReg <= 2'b00;
                    ctrl.bOrL     <= 1'b0;
                    ctrl.regWrite <= 1'b1;
                end
                stImmExecute: begin
                    state         <= stImmWriteback;
                    ctrl.regDst   <= 2'b00;
                    ctrl.memToReg <= 2'b00;
                    ctrl.regWrite <= 1'b1;
                    ctrl.andiOri  <= 1'b0;
                end
                stFpuExecute:  state <= stFpuWait;
                stFpuWait: begin
                    if (waitCnt == `FPU_CNT_W'd1) begin
                        state         <= stFpuWriteback;
                        ctrl.regDst   <= 2'b01;
                        ctrl.memToReg <= 2'b00;
                        ctrl.regWrite <= 1'b1;
                        ctrl.aluOrFpu <= 1'b0;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                stFsltExecute: begin
                    state         <= stFsltWriteback;
                    ctrl.regDst   <= 2'b01;
                    ctrl.memToReg <= 2'b00;
                    ctrl.regWrite <= 1'b1;
                    ctrl.aluOrFpu <= 1'b0;
                end
                // every writeback, branch, jump and illegal state ends here
                default: begin
                    state <= stFetch;
                    ctrl  <= toFetch(ctrl);
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) ctrl.irWrite |=> !ctrl.irWrite)
        else $error("irWrite high on two consecutive cycles");

    assert property (@(posedge clk) disable iff (!rstn) ctrl.memWrite |-> ctrl.iOrD)
        else $error("memWrite without iOrD");

    // unknown codes fall back to fetch, flag them
    assert property (@(posedge clk) disable iff (!rstn) (state == stDecode) |-> opKnown)
        else $warning("unknown opcode %h in decode", op);

endmodule

`default_nettype wire

// File: hdl/aluDecoder.sv
`default_nettype none

`include "ctrl_params.svh"

module aluDecoder
    import ctrlPkg::*;
(
    input  logic [`ALUCLS_W-1:0]     aluClass,
    input  logic [`CTRL_FUNCT_W-1:0] funct,
    output aluCtrl_t                 alu
);

    logic [`ALU_OP_W-1:0] functOp;

    // R-type operation from funct
    always_comb begin
        case (funct)
            `FN_SUB: functOp = `ALU_SUB;
            `FN_AND: functOp = `ALU_AND;
            `FN_OR:  functOp = `ALU_OR;
            `FN_SLT: functOp = `ALU_SLT;
            // add, jr, jalr and the shifts all use the adder
            default: functOp = `ALU_ADD;
        endcase
    end

    always_comb begin
        case (aluClass)
            `ALUCLS_SUB:   alu.aluControl = `ALU_SUB;
            `ALUCLS_AND:   alu.aluControl = `ALU_AND;
            `ALUCLS_OR:    alu.aluControl = `ALU_OR;
            `ALUCLS_SLT:   alu.aluControl = `ALU_SLT;
            `ALUCLS_RTYPE: alu.aluControl = functOp;
            default:       alu.aluControl = `ALU_ADD;
        endcase

        alu.shift      = (funct == `FN_SLL) || (funct == `FN_SRL);
        alu.shiftRight = (funct == `FN_SRL); // logical right
    end

endmodule

`default_nettype wire

// File: hdl/pcRegSelect.sv
`default_nettype none

`include "ctrl_params.svh"

module pcRegSelect
    import ctrlPkg::*;
(
    input  logic [`CTRL_OP_W-1:0]    op,
    input  logic [`CTRL_FUNCT_W-1:0] funct,
    input  seqState_t                state,
    input  logic                     pcWriteReq,
    input  logic [1:0]               pcSrcReq,
    output pcCtrl_t                  pc
);

    logic regJump;

    // jr and jalr load the pc from rs, only visible once funct is known
    assign regJump = (op == `OP_RTYPE) &&
                     (((funct == `FN_JR) && (state == stExecute)) ||
                      ((funct == `FN_JALR) && (state == stJumpAndLinkReg)));

    always_comb begin
        pc.pcWrite = regJump ? 1'b1 : pcWriteReq;
        pc.pcSrc   = regJump ? 2'b00 : pcSrcReq;

        if (op == `OP_FSLT)
            pc.regConcat = 3'b110;  // float sources, int dest
        else if (op == `OP_FLW)
            pc.regConcat = 3'b001;
        else if (op == `OP_FSW)
            pc.regConcat = 3'b010;
        else if (op[4:3] == 2'b10)
            pc.regConcat = 3'b111;  // remaining float arithmetic
        else
            pc.regConcat = 3'b000;
    end

    // branch is only raised by the sequencer while in stBranch
    always_comb begin
        assert final (!(pc.pcWrite && (state == stBranch)))
            else $error("pcWrite and branch both high");
    end

endmodule

`default_nettype wire

// File: hdl/multiControlUnit.sv
`default_nettype none

`include "ctrl_params.svh"

module multiControlUnit
    import ctrlPkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`CTRL_OP_W-1:0]    op,
    input  logic [`CTRL_FUNCT_W-1:0] funct,
    output seqCtrl_t                 ctrl,
    output aluCtrl_t                 alu,
    output pcCtrl_t                  pc,
    output seqState_t                state
);

    mainSequencer sequencer (
        .clk   (clk),
        .rstn  (rstn),
        .op    (op),
        .funct (funct),
        .ctrl  (ctrl),
        .state (state)
    );

    aluDecoder aluDec (
        .aluClass (ctrl.aluClass),
        .funct    (funct),
        .alu      (alu)
    );

    // pc override and register bank select
    pcRegSelect pcSel (
        .op         (op),
        .funct      (funct),
        .state      (state),
        .pcWriteReq (ctrl.pcWriteReq),
        .pcSrcReq   (ctrl.pcSrcReq),
        .pc         (pc)
    );

endmodule

`default_nettype wire

// File: testbench/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

`include "ctrl_params.svh"

// opcodes the unit decodes, R-type listed once
localparam logic [`CTRL_OP_W-1:0] keptOps [22] = '{
    `OP_RTYPE, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_ADDI, `OP_SLTI, `OP_ANDI,
    `OP_ORI, `OP_LUI, `OP_FADD, `OP_FSUB, `OP_FMUL, `OP_FDIV, `OP_FNEG, `OP_FABS,
    `OP_FSQRT, `OP_FSLT, `OP_LW, `OP_SW, `OP_FLW, `OP_FSW
};

localparam logic [`CTRL_FUNCT_W-1:0] rtypeFuncts [9] = '{
    `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLL, `FN_SRL, `FN_JR, `FN_JALR
};

function automatic bit knownOpcode(logic [`CTRL_OP_W-1:0] o);
    foreach (keptOps[i])
        if (keptOps[i] == o)
            return 1'b1;
    return 1'b0;
endfunction

function automatic bit floatOp(logic [`CTRL_OP_W-1:0] o);
    return o == `OP_FADD || o == `OP_FSUB || o == `OP_FMUL || o == `OP_FDIV ||
           o == `OP_FNEG || o == `OP_FABS || o == `OP_FSQRT || o == `OP_FSLT;
endfunction

// opcodes whose writeback goes through the ALU class decoder
function automatic bit usesAluClass(logic [`CTRL_OP_W-1:0] o);
    return o == `OP_RTYPE || o == `OP_ADDI || o == `OP_ANDI ||
           o == `OP_ORI || o == `OP_SLTI;
endfunction

// cycles from one irWrite pulse to the next
function automatic int cycleCount(logic [`CTRL_OP_W-1:0] o);
    case (o)
        `OP_LW, `OP_FLW:                       return 7;
        `OP_SW, `OP_FSW, `OP_RTYPE, `OP_LUI:   return 5;
        `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_SLTI: return 5;
        `OP_BEQ, `OP_BNE, `OP_J, `OP_JAL:      return 4;
        `OP_FADD, `OP_FSUB:                    return 8;
        `OP_FMUL, `OP_FSQRT:                   return 7;
        `OP_FDIV:                              return 10;
        `OP_FNEG, `OP_FABS, `OP_FSLT:          return 5;
        default:                               return 4; // straight back to fetch
    endcase
endfunction

function automatic logic [`ALU_OP_W-1:0] aluOpFor(logic [`CTRL_OP_W-1:0] o,
                                                  logic [`CTRL_FUNCT_W-1:0] f);
    case (o)
        `OP_ANDI: return `ALU_AND;
        `OP_ORI:  return `ALU_OR;
        `OP_SLTI: return `ALU_SLT;
        `OP_RTYPE: begin
            case (f)
                `FN_SUB: return `ALU_SUB;
                `FN_AND: return `ALU_AND;
                `FN_OR:  return `ALU_OR;
                `FN_SLT: return `ALU_SLT;
                default: return `ALU_ADD; // add, jr, jalr, sll, srl
            endcase
        end
        default: return `ALU_ADD;
    endcase
endfunction

function automatic logic [`FPU_OP_W-1:0] fpuCodeFor(logic [`CTRL_OP_W-1:0] o);
    case (o)
        `OP_FSUB:  return `FPU_SUB;
        `OP_FMUL:  return `FPU_MUL;
        `OP_FDIV:  return `FPU_DIV;
        `OP_FNEG:  return `FPU_NEG;
        `OP_FABS:  return `FPU_ABS;
        `OP_FSQRT: return `FPU_SQRT;
        `OP_FSLT:  return `FPU_SLT;
        default:   return `FPU_ADD;
    endcase
endfunction

// {rs, rt, rd} float bank select
function automatic logic [2:0] bankSelect(logic [`CTRL_OP_W-1:0] o);
    if (o == `OP_FSLT)
        return 3'b110;
    if (o == `OP_FLW)
        return 3'b001;
    if (o == `OP_FSW)
        return 3'b010;
    if (o[4:3] == 2'b10)
        return 3'b111;
    return 3'b000;
endfunction

`endif

// File: testbench/tbControlUnit.sv
`default_nettype none

`include "ctrl_params.svh"

module tbControlUnit
    import ctrlPkg::*;
();

    logic                     clk;
    logic                     rstn;
    logic [`CTRL_OP_W-1:0]    op;
    logic [`CTRL_FUNCT_W-1:0] funct;
    seqCtrl_t                 ctrl;
    aluCtrl_t                 alu;
    pcCtrl_t                  pc;
    seqState_t                state;

    integer seed;
    int     valueErrs;
    int     protoErrs;
    bit     timedOut;

    `include "controlModel.svh"

    multiControlUnit dut (
        .clk   (clk),
        .rstn  (rstn),
        .op    (op),
        .funct (funct),
        .ctrl  (ctrl),
        .alu   (alu),
        .pc    (pc),
        .state (state)
    );

    always #50 clk = ~clk;

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got == want) else begin
            $display("ERR %s got %0h expected %0h", name, got, want);
            valueErrs++;
        end
    endtask

    task automatic verifyResetState();
        compareField("iOrD", ctrl.iOrD, 0);
        compareField("memWrite", ctrl.memWrite, 0);
        compareField("irWrite", ctrl.irWrite, 0);
        compareField("branch", ctrl.branch, 0);
        compareField("toggleEqual", ctrl.toggleEqual, 0);
        compareField("regWrite", ctrl.regWrite, 0);
        compareField("aluOrFpu", ctrl.aluOrFpu, 0);
        compareField("pcWriteReq", ctrl.pcWriteReq, 1);
        compareField("aluSrcB", ctrl.aluSrcB, 2'b01);
        compareField("state", state, stFetch);
    endtask

    task automatic waitFirstFetch();
        int idx;
        idx = 0;
        while (!ctrl.irWrite && !timedOut) begin
            @(negedge clk);
            idx++;
            if (!ctrl.irWrite && idx >= 20) begin
                $display("no instruction fetch seen");
                protoErrs++;
                timedOut = 1'b1;
            end
        end
        if (!timedOut)
            compareField("cycles to first irWrite", idx, 1);
    endtask

    // runs one instruction from the irWrite pulse that latches it to the next one
    task automatic executeInstruction();
        int                       pick;
        int                       want;
        int                       idx;
        int                       regJumps;
        int                       jumps;
        int                       branches;
        int                       stores;
        bit                       wbSeen;
        bit                       fpuBusy;
        bit                       inWindow;
        logic [`CTRL_OP_W-1:0]    curOp;
        logic [`CTRL_FUNCT_W-1:0] curFunct;

        pick     = ($random(seed) & 32'h7fff_ffff) % 27;
        curFunct = 6'($random(seed));
        if (pick < 22) begin
            curOp = keptOps[pick];
        end else if (pick < 25) begin
            curOp = `OP_RTYPE; // extra weight for the nine functs
        end else begin
            curOp = 6'($random(seed));
            if (knownOpcode(curOp))
                curOp = 6'b111111;
        end
        if (curOp == `OP_RTYPE)
            curFunct = rtypeFuncts[($random(seed) & 32'h7fff_ffff) % 9];

        @(posedge clk);
        op       <= curOp;
        funct    <= curFunct;
        want     = cycleCount(curOp);
        idx      = 0;
        regJumps = 0;
        jumps    = 0;
        branches = 0;
        stores   = 0;
        wbSeen   = 1'b0;

        while (!timedOut) begin
            @(negedge clk);
            idx++;
            fpuBusy  = floatOp(curOp) && idx >= 2 && idx <= want - 3;
            inWindow = idx >= 2 && idx <= want - 2; // after decode and before fetch
            compareField("regConcat", pc.regConcat, bankSelect(curOp));
            compareField("aluOrFpu", ctrl.aluOrFpu, fpuBusy);
            if (fpuBusy)
                compareField("fpuControl", ctrl.fpuControl, fpuCodeFor(curOp));
            if (inWindow && pc.pcWrite && pc.pcSrc == 2'b00)
                regJumps++;
            if (inWindow && pc.pcWrite && pc.pcSrc == 2'b10)
                jumps++;
            if (ctrl.branch) begin
                branches++;
                compareField("toggleEqual", ctrl.toggleEqual, curOp == `OP_BNE);
            end
            if (ctrl.memWrite)
                stores++;
            if (ctrl.regWrite && !wbSeen) begin
                wbSeen = 1'b1;
                if (usesAluClass(curOp)) begin
                    compareField("aluControl", alu.aluControl, aluOpFor(curOp, curFunct));
                    compareField("shift", alu.shift,
                                 curFunct == `FN_SLL || curFunct == `FN_SRL);
                    compareField("shiftRight", alu.shiftRight, curFunct == `FN_SRL);
                end
                if (curOp == `OP_LW || curOp == `OP_FLW) begin
                    compareField("iOrD", ctrl.iOrD, 1);
                    compareField("memToReg", ctrl.memToReg, 2'b01);
                end
            end
            if (ctrl.irWrite)
                break;
            if (idx >= 20) begin
                $display("no instruction fetch seen");
                protoErrs++;
                timedOut = 1'b1;
            end
        end

        if (!timedOut) begin
            compareField("cycles", idx, want);
            compareField("pcWrite with pcSrc 00", regJumps,
                         curOp == `OP_RTYPE &&
                         (curFunct == `FN_JR || curFunct == `FN_JALR));
            compareField("pcWrite with pcSrc 10", jumps, curOp == `OP_J || curOp == `OP_JAL);
            compareField("branch cycles", branches, curOp == `OP_BEQ || curOp == `OP_BNE);
            compareField("memWrite cycles", stores, curOp == `OP_SW || curOp == `OP_FSW);
            if (usesAluClass(curOp) || curOp == `OP_LW || curOp == `OP_FLW) begin
                assert (wbSeen) else begin
                    $display("no register writeback for opcode %0h", curOp);
                    protoErrs++;
                end
            end
        end
    endtask

    initial begin
        int n;
        clk       = 1'b0;
        rstn      = 1'b0;
        op        = '0;
        funct     = '0;
        seed      = 45821;
        valueErrs = 0;
        protoErrs = 0;
        timedOut  = 1'b0;

        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        verifyResetState();
        waitFirstFetch();

        for (n = 0; n < 400 && !timedOut; n++)
            executeInstruction();

        $display("errors: %0d value, %0d protocol", valueErrs, protoErrs);
        if (valueErrs == 0 && protoErrs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
+incdir+testbench
hdl/ctrlPkg.sv
hdl/mainSequencer.sv
hdl/aluDecoder.sv
hdl/pcRegSelect.sv
hdl/multiControlUnit.sv
testbench/tbControlUnit.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for a failure in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tbControlUnit -o simControlUnit > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simControlUnit > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
